//--- lcdBiasPwm.sv
// Generates the four bias-level PWM streams that the external RC filters smooth
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdBiasPwm (
	input  wire                     Clock,
	input  wire                     Reset,
	output logic [`LCD_PWM_STEPS:0] Voltage_o
);

	logic [1:0] Step;

	// Runs 0, 1, 2, 0, ...
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Step <= 2'd0;
		end else if (Step == 2'(`LCD_PWM_STEPS - 1)) begin
			Step <= 2'd0;
		end else begin
			Step <= Step + 2'd1;
		end
	end

	// Stream k is high for k of every three cycles
	// so stream 0 stays low and stream 3 stays high
	genvar k;
	generate
		for (k = 0; k <= `LCD_PWM_STEPS; k++) begin : genLevel
			assign Voltage_o[k] = (Step < 2'(k));
		end
	endgenerate

endmodule

`default_nettype wire

//--- lcdDrivePkg.sv
// Types describing the multiplexed drive (bias levels and phases), imported by the drive modules
`default_nettype none

`include "lcd_consts.svh"

package lcdDrivePkg;

	// Bias level in thirds of full voltage
	typedef logic [1:0] levelT;

	// Frame half
	typedef enum logic {
		PolHigh = 1'b0,
		PolLow  = 1'b1
	} polarityE;

	// Phase number is polarity * 4 + comIndex
	typedef struct packed {
		polarityE                          polarity;
		logic [$clog2(`LCD_COMS)-1:0]      comIndex;
	} phaseT;

	// Level codes while a polarity is in effect
	localparam levelT LevelGnd   = 2'd0;
	localparam levelT LevelThird = 2'd1;
	localparam levelT LevelTwo   = 2'd2;
	localparam levelT LevelFull  = 2'd3;

	// In low polarity every code is mirrored around half supply
	function automatic levelT applyPolarity(levelT High, polarityE Pol);
		levelT Result;
		Result = (Pol == PolLow) ? ~High : High;
		return Result;
	endfunction

endpackage

`default_nettype wire

//--- lcdGlassPkg.sv
// Types describing the fifteen-segment glass, imported by the segment selector and top level
`default_nettype none

`include "lcd_consts.svh"

package lcdGlassPkg;

	// One character, bit 0 is segment a
	typedef logic [`LCD_BITMAP_BITS-1:0] bitmapT;

	// Bit position of each letter inside bitmapT, there is no letter o
	typedef enum logic [3:0] {
		SegA = 4'd0,
		SegB = 4'd1,
		SegC = 4'd2,
		SegD = 4'd3,
		SegE = 4'd4,
		SegF = 4'd5,
		SegG = 4'd6,
		SegH = 4'd7,
		SegI = 4'd8,
		SegJ = 4'd9,
		SegK = 4'd10,
		SegL = 4'd11,
		SegM = 4'd12,
		SegN = 4'd13,
		SegP = 4'd14
	} segLetterE;

	// Segment lines of a character, pin is 4 * char + line
	typedef enum logic [$clog2(`LCD_LINES)-1:0] {
		LineAbcp = 2'd0,
		LineFed  = 2'd1,
		LineIjkn = 2'd2,
		LineHglm = 2'd3
	} segLineE;

endpackage

`default_nettype wire

//--- lcdLevelDriver.sv
// Registers a bias level per COM and segment pin and routes the matching PWM stream to it
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdLevelDriver
	import lcdDrivePkg::*;
(
	input  wire                       Clock,
	input  wire                       Reset,
	input  phaseT                     Phase_i,
	input  wire [`LCD_SEG_PINS-1:0]   SegOn_i,
	input  wire [`LCD_PWM_STEPS:0]    Voltage_i,
	output logic [`LCD_COMS-1:0]      ComPin_o,
	output logic [`LCD_SEG_PINS-1:0]  SegPin_o
);

	levelT [`LCD_COMS-1:0]     ComLevel;
	levelT [`LCD_COMS-1:0]     ComNext;
	levelT [`LCD_SEG_PINS-1:0] SegLevel;
	levelT [`LCD_SEG_PINS-1:0] SegNext;

	// Level rule written for high polarity, mirrored for low
	always_comb begin
		for (int i = 0; i < `LCD_COMS; i++) begin
			ComNext[i] = applyPolarity((Phase_i.comIndex == i) ? LevelFull : LevelThird,
				Phase_i.polarity);
		end
		for (int s = 0; s < `LCD_SEG_PINS; s++) begin
			SegNext[s] = applyPolarity(SegOn_i[s] ? LevelGnd : LevelTwo, Phase_i.polarity);
		end
	end

	// Reset state equals phase 0 with every segment off
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			for (int i = 0; i < `LCD_COMS; i++) begin
				ComLevel[i] <= (i == 0) ? LevelFull : LevelThird;
			end
			for (int s = 0; s < `LCD_SEG_PINS; s++) begin
				SegLevel[s] <= LevelTwo;
			end
		end else begin
			ComLevel <= ComNext;
			SegLevel <= SegNext;
		end
	end

	// Each pin carries the PWM stream of its level
	genvar p;
	generate
		for (p = 0; p < `LCD_COMS; p++) begin : genCom
			assign ComPin_o[p] = Voltage_i[ComLevel[p]];
		end
		for (p = 0; p < `LCD_SEG_PINS; p++) begin : genSeg
			assign SegPin_o[p] = Voltage_i[SegLevel[p]];
		end
	endgenerate

endmodule

`default_nettype wire

//--- lcdPhaseSequencer.sv
// Divides the clock to the COM change period and steps the eight drive phases
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdPhaseSequencer
	import lcdDrivePkg::*;
#(
	parameter int PhaseCycles = 10000
)(
	input  wire   Clock,
	input  wire   Reset,
	output phaseT Phase_o
);

	localparam int CountBits = $clog2(PhaseCycles + 1);

	logic [CountBits-1:0] Count;
	logic                 ChangePhase;
	logic [2:0]           PhaseNum;

	// Last cycle of the current phase
	assign ChangePhase = (Count == CountBits'(1));

	// Down-counter, reloads after its last cycle
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			Count <= CountBits'(PhaseCycles);
		end else if (ChangePhase) begin
			Count <= CountBits'(PhaseCycles);
		end else begin
			Count <= Count - 1'b1;
		end
	end

	// 0..3 high polarity, 4..7 low polarity, wraps back to COM0 high
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			PhaseNum <= 3'd0;
		end else if (ChangePhase) begin
			PhaseNum <= PhaseNum + 3'd1;
		end
	end

	assign Phase_o = phaseT'(PhaseNum);

endmodule

`default_nettype wire

//--- lcdSegmentSelect.sv
// Picks the on/off state of every segment line for the COM that is currently driven
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdSegmentSelect
	import lcdGlassPkg::*;
	import lcdDrivePkg::*;
(
	input  bitmapT [`LCD_CHARS-1:0]    Bitmap_i,
	input  phaseT                      Phase_i,
	output logic [`LCD_SEG_PINS-1:0]   SegOn_o
);

	localparam int ComBits = $clog2(`LCD_COMS);

	// Letter driven by each line, indexed [line][com]
	localparam segLetterE LetterMap [`LCD_LINES][`LCD_COMS] = '{
		'{SegA, SegB, SegC, SegP},   // ABCP
		'{SegA, SegF, SegE, SegD},   // FED, COM0 slot unused
		'{SegI, SegJ, SegK, SegN},   // IJKN
		'{SegH, SegG, SegL, SegM}    // HGLM
	};

	function automatic logic pickSegment(
		bitmapT              Bitmap,
		segLineE             Line,
		logic [ComBits-1:0]  Com
	);
		logic Present;
		Present = !((Line == LineFed) && (Com == '0));
		return Present && Bitmap[LetterMap[Line][Com]];
	endfunction

	// Polarity plays no part here, both halves show the same segments
	genvar c, l;
	generate
		for (c = 0; c < `LCD_CHARS; c++) begin : genChar
			for (l = 0; l < `LCD_LINES; l++) begin : genLine
				assign SegOn_o[`LCD_LINES*c + l] =
					pickSegment(Bitmap_i[c], segLineE'(l), Phase_i.comIndex);
			end
		end
	endgenerate

endmodule

`default_nettype wire

//--- lcdTb.sv
// Testbench for lcdTop, drives bitmaps from lcd_stim.txt and measures the PWM level of every pin
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdTb
	import lcdGlassPkg::*;
	import lcdDrivePkg::*;
();

	localparam int ClockHz      = 1_000_000;
	localparam int ChangeComUs  = 30;
	localparam int PhaseCycles  = (ClockHz / 1000) * ChangeComUs / 1000;
	localparam int FrameCycles  = 2 * `LCD_COMS * PhaseCycles;
	localparam int NumRows      = 6;
	localparam int WordsPerRow  = `LCD_CHARS + `LCD_COMS;
	localparam int ResetCycles  = 10;
	localparam int WindowStart  = 4;                  // Three cycles past the pin boundary
	localparam int WindowLate   = PhaseCycles - 2;    // Last full window of a phase
	localparam int TimeoutCycles = 2 * ResetCycles + NumRows * FrameCycles + 100;

	logic                      Clock;
	logic                      Reset;
	bitmapT [`LCD_CHARS-1:0]   Bitmap;
	logic [`LCD_COMS-1:0]      ComPin;
	logic [`LCD_SEG_PINS-1:0]  SegPin;

	logic [31:0] StimMem [0:NumRows*WordsPerRow-1];

	int CycleCount;        // Rising edges since reset release
	int TotalCycles = 0;
	int ErrorCount = 0;
	int CheckCount = 0;
	int TestsPassed = 0;
	int TestsFailed = 0;
	int TestErrors [1:6];

	levelT [`LCD_COMS-1:0]     ComMeas;
	levelT [`LCD_SEG_PINS-1:0] SegMeas;

	lcdTop #(
		.ClockHz     (ClockHz),
		.ChangeComUs (ChangeComUs)
	) DUT (
		.Clock    (Clock),
		.Reset    (Reset),
		.Bitmap_i (Bitmap),
		.ComPin_o (ComPin),
		.SegPin_o (SegPin)
	);

	bind lcdLevelDriver lcdDriverProperties levelProps (
		.Clock      (Clock),
		.Reset      (Reset),
		.Phase_i    (Phase_i),
		.ComLevel_i (ComLevel),
		.SegLevel_i (SegLevel),
		.Voltage_i  (Voltage_i)
	);

	initial Clock = 1'b0;
	always #10 Clock = ~Clock;

	always @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			CycleCount <= 0;
		end else begin
			CycleCount <= CycleCount + 1;
		end
	end

	always @(posedge Clock) begin
		TotalCycles <= TotalCycles + 1;
		if (TotalCycles >= TimeoutCycles) begin
			$display("Timeout: run did not end within %0d cycles", TimeoutCycles);
			$display("Finished with errors");
			$finish;
		end
	end

	// Expected levels straight from the drive table
	function automatic levelT comLevel(input polarityE Pol, input logic Active);
		if (Pol == PolHigh) return Active ? 2'd3 : 2'd1;
		return Active ? 2'd0 : 2'd2;
	endfunction

	function automatic levelT segLevel(input polarityE Pol, input logic On);
		if (Pol == PolHigh) return On ? 2'd0 : 2'd2;
		return On ? 2'd3 : 2'd1;
	endfunction

	function automatic phaseT makePhase(input int Num);
		phaseT P;
		P.polarity = (Num >= `LCD_COMS) ? PolLow : PolHigh;
		P.comIndex = 2'(Num % `LCD_COMS);
		return P;
	endfunction

	function automatic logic [31:0] rowMask(input int Row, input int Com);
		return StimMem[Row*WordsPerRow + `LCD_CHARS + Com];
	endfunction

	// File lists character 7 first
	task automatic loadRow(input int Row);
		for (int j = 0; j < `LCD_CHARS; j++) begin
			Bitmap[`LCD_CHARS-1-j] = StimMem[Row*WordsPerRow + j][`LCD_BITMAP_BITS-1:0];
		end
	endtask

	task automatic waitForCycle(input int Target);
		if (CycleCount > Target) begin
			$display("Error: measurement window at cycle %0d was already passed (now %0d)",
				Target, CycleCount);
			ErrorCount++;
		end
		while (CycleCount < Target) @(negedge Clock);
	endtask

	// High samples over one PWM period give the level
	task automatic measureLevels;
		ComMeas = '0;
		SegMeas = '0;
		for (int n = 0; n < `LCD_PWM_STEPS; n++) begin
			if (n > 0) @(negedge Clock);
			for (int i = 0; i < `LCD_COMS; i++) ComMeas[i] = ComMeas[i] + levelT'(ComPin[i]);
			for (int s = 0; s < `LCD_SEG_PINS; s++) SegMeas[s] = SegMeas[s] + levelT'(SegPin[s]);
		end
	endtask

	task automatic checkLevel(input int TestIdx, input string Name, input levelT Got,
		input levelT Expected);
		CheckCount++;
		if (Got !== Expected) begin
			$display("[FAIL] %s got %h expected %h at %0t", Name, Got, Expected, $time);
			ErrorCount++;
			TestErrors[TestIdx]++;
		end
	endtask

	task automatic checkPhase(input int TestIdx, input phaseT Got, input phaseT Expected);
		CheckCount++;
		if (Got !== Expected) begin
			$display("[FAIL] Phase from ComPin_o got %h expected %h at %0t", Got, Expected, $time);
			ErrorCount++;
			TestErrors[TestIdx]++;
		end
	endtask

	// Active COM sits at 0 or 3, its level gives the polarity
	task automatic decodePhase(output phaseT Phase, output logic Valid);
		int Active;
		Active = 0;
		Phase = '0;
		for (int i = 0; i < `LCD_COMS; i++) begin
			if (ComMeas[i] == 2'd0 || ComMeas[i] == 2'd3) begin
				Active++;
				Phase.comIndex = 2'(i);
				Phase.polarity = (ComMeas[i] == 2'd3) ? PolHigh : PolLow;
			end
		end
		Valid = (Active == 1);
	endtask

	task automatic checkPhaseOnly(input int TestIdx, input phaseT Expected);
		phaseT Decoded;
		logic  Valid;
		decodePhase(Decoded, Valid);
		if (!Valid) begin
			$display("Error: COM pins do not show exactly one active COM at %0t", $time);
			ErrorCount++;
			TestErrors[TestIdx]++;
		end else begin
			checkPhase(TestIdx, Decoded, Expected);
		end
	endtask

	task automatic checkPins(input int TestIdx, input phaseT Expected, input logic [31:0] OnMask);
		checkPhaseOnly(TestIdx, Expected);
		for (int i = 0; i < `LCD_COMS; i++) begin
			checkLevel(TestIdx, $sformatf("ComPin_o[%0d]", i), ComMeas[i],
				comLevel(Expected.polarity, Expected.comIndex == 2'(i)));
		end
		for (int s = 0; s < `LCD_SEG_PINS; s++) begin
			checkLevel(TestIdx, $sformatf("SegPin_o[%0d]", s), SegMeas[s],
				segLevel(Expected.polarity, OnMask[s]));
		end
	endtask

	task automatic finishTest(input int TestIdx, input string Name);
		if (TestErrors[TestIdx] == 0) begin
			$display("Test %s: ok", Name);
			TestsPassed++;
		end else begin
			$display("Test %s: %0d errors", Name, TestErrors[TestIdx]);
			TestsFailed++;
		end
	endtask

	initial begin
		phaseT       Expected;
		int          Base;
		logic [31:0] NewMask;
		logic [31:0] OldMask;
		Reset = 1'b0;
		Bitmap = '0;
		for (int t = 1; t <= 6; t++) TestErrors[t] = 0;
		$readmemh("lcd_stim.txt", StimMem);
		if (^StimMem[NumRows*WordsPerRow-1] === 1'bx) begin
			$display("Error: stimulus file lcd_stim.txt is missing or too short");
			ErrorCount++;
		end
		repeat (ResetCycles) @(negedge Clock);
		loadRow(0);
		Reset = 1'b1;

		for (int r = 0; r < NumRows; r++) begin
			Base = r * FrameCycles;
			waitForCycle(Base);
			loadRow(r);           // Frame boundary
			TestErrors[3] = 0;
			for (int k = 0; k < 2 * `LCD_COMS; k++) begin
				Expected = makePhase(k);
				waitForCycle(Base + k*PhaseCycles + WindowStart);
				measureLevels();
				if (r == 0 && k == 0) begin
					checkPins(1, Expected, 32'h0);   // Row 0 is a blank glass
					finishTest(1, "1 levels after reset");
				end
				checkPins(3, Expected, rowMask(r, k % `LCD_COMS));
				// FED line has no letter on COM0
				if (Expected.comIndex == 0) begin
					for (int c = 0; c < `LCD_CHARS; c++) begin
						checkLevel(4, $sformatf("SegPin_o[%0d]", `LCD_LINES*c + 1),
							SegMeas[`LCD_LINES*c + 1], segLevel(Expected.polarity, 1'b0));
					end
				end
				if (r > 0 && k == 0) begin
					NewMask = rowMask(r, 0);
					OldMask = rowMask(r - 1, 0);
					for (int s = 0; s < `LCD_SEG_PINS; s++) begin
						if (NewMask[s] != OldMask[s]) begin
							checkLevel(5, $sformatf("SegPin_o[%0d]", s), SegMeas[s],
								segLevel(PolHigh, NewMask[s]));
						end
					end
				end
				if (r == 0) begin
					checkPhaseOnly(2, Expected);
					waitForCycle(Base + k*PhaseCycles + WindowLate);
					measureLevels();
					checkPhaseOnly(2, Expected);   // Still held in its 30th cycle
				end
			end
			if (r == 0) finishTest(2, "2 phase sequence");
			finishTest(3, $sformatf("3 row %0d segment levels", r));
		end
		finishTest(4, "4 FED line off on COM0");
		finishTest(5, "5 bitmap change at frame boundary");

		// Reset in phase 1 of the next frame
		waitForCycle(NumRows * FrameCycles + PhaseCycles + 10);
		Reset = 1'b0;
		Bitmap = '0;
		repeat (ResetCycles) @(negedge Clock);
		Reset = 1'b1;
		waitForCycle(WindowStart);
		measureLevels();
		checkPins(6, makePhase(0), 32'h0);
		waitForCycle(WindowLate);
		measureLevels();
		checkPhaseOnly(6, makePhase(0));
		waitForCycle(PhaseCycles + WindowStart);
		measureLevels();
		checkPins(6, makePhase(1), 32'h0);
		finishTest(6, "6 reset in mid-frame");

		$display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
			TestsPassed, TestsFailed, CheckCount, ErrorCount);
		if (ErrorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- lcdTop.sv
// Top level of the 1/3-bias, 1/4-duty LCD driver, chaining timer, PWM, selector and pin drivers
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdTop
	import lcdGlassPkg::*;
	import lcdDrivePkg::*;
#(
	parameter int ClockHz     = `LCD_CLOCK_HZ,
	parameter int ChangeComUs = `LCD_CHANGE_COM_US
)(
	input  wire                        Clock,
	input  wire                        Reset,
	input  bitmapT [`LCD_CHARS-1:0]    Bitmap_i,     // Character 0 is rightmost
	output logic [`LCD_COMS-1:0]       ComPin_o,     // Each pin needs an RC filter
	output logic [`LCD_SEG_PINS-1:0]   SegPin_o      // Char c, line l on pin 4c+l
);

	// Wide product, 10 MHz times 1000 us does not fit in 32 bits
	localparam longint PhaseCyclesWide = longint'(ClockHz) * longint'(ChangeComUs) / 1_000_000;
	localparam int     PhaseCycles     = int'(PhaseCyclesWide);

	phaseT                      Phase;
	logic [`LCD_PWM_STEPS:0]    Voltage;
	logic [`LCD_SEG_PINS-1:0]   SegOn;

	lcdPhaseSequencer #(
		.PhaseCycles(PhaseCycles)
	) phaseSequencer (
		.Clock   (Clock),
		.Reset   (Reset),
		.Phase_o (Phase)
	);

	lcdBiasPwm biasPwm (
		.Clock     (Clock),
		.Reset     (Reset),
		.Voltage_o (Voltage)
	);

	lcdSegmentSelect segmentSelect (
		.Bitmap_i (Bitmap_i),
		.Phase_i  (Phase),
		.SegOn_o  (SegOn)
	);

	lcdLevelDriver levelDriver (
		.Clock     (Clock),
		.Reset     (Reset),
		.Phase_i   (Phase),
		.SegOn_i   (SegOn),
		.Voltage_i (Voltage),
		.ComPin_o  (ComPin_o),
		.SegPin_o  (SegPin_o)
	);

endmodule

`default_nettype wire

//--- lcd_consts.svh
// Glass geometry, PWM and default timing constants, included by every design file
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// Glass geometry
`define LCD_CHARS        8       // Characters, 0 is rightmost
`define LCD_COMS         4       // Backplane lines
`define LCD_LINES        4       // Segment lines per character
`define LCD_SEG_PINS     32      // LCD_CHARS * LCD_LINES
`define LCD_BITMAP_BITS  15      // Letters a..n, p

// One PWM period gives levels 0, 1/3, 2/3 and full
`define LCD_PWM_STEPS    3

// Default timing
`define LCD_CLOCK_HZ       10_000_000
`define LCD_CHANGE_COM_US  1000  // Time each phase is held

`endif

//--- lcd_properties.sv
// Assertions on the level driver's registered codes and bias streams, bound into lcdLevelDriver
`default_nettype none
`timescale 1ns/1ps

`include "lcd_consts.svh"

module lcdDriverProperties
	import lcdDrivePkg::*;
(
	input  wire                        Clock,
	input  wire                        Reset,
	input  phaseT                      Phase_i,
	input  levelT [`LCD_COMS-1:0]      ComLevel_i,
	input  levelT [`LCD_SEG_PINS-1:0]  SegLevel_i,
	input  wire [`LCD_PWM_STEPS:0]     Voltage_i
);

	polarityE              CodePol;     // Polarity of the registered codes
	logic [`LCD_COMS-1:0]  ActiveCom;
	logic                  SegInRange;

	// Codes lag Phase_i by one cycle
	always_ff @(posedge Clock, negedge Reset) begin
		if (!Reset) begin
			CodePol <= PolHigh;
		end else begin
			CodePol <= Phase_i.polarity;
		end
	end

	always_comb begin
		for (int i = 0; i < `LCD_COMS; i++) begin
			ActiveCom[i] = (ComLevel_i[i] == 2'd0) || (ComLevel_i[i] == 2'd3);
		end
		SegInRange = 1'b1;
		for (int s = 0; s < `LCD_SEG_PINS; s++) begin
			if (CodePol == PolHigh) begin
				if (SegLevel_i[s] != 2'd0 && SegLevel_i[s] != 2'd2) SegInRange = 1'b0;
			end else begin
				if (SegLevel_i[s] != 2'd1 && SegLevel_i[s] != 2'd3) SegInRange = 1'b0;
			end
		end
	end

	oneActiveCom: assert property (@(posedge Clock) disable iff (!Reset)
		$countones(ActiveCom) == 1)
		else $error("COM codes do not select exactly one active COM");

	segCodeAllowed: assert property (@(posedge Clock) disable iff (!Reset) SegInRange)
		else $error("Segment code outside the pair for the current polarity");

	biasRails: assert property (@(posedge Clock) disable iff (!Reset)
		!Voltage_i[0] && Voltage_i[`LCD_PWM_STEPS])
		else $error("Bias stream 0 went high or stream 3 went low");

endmodule

`default_nettype wire

//--- lcd_stim.txt
// Columns: bitmaps of char 7 down to char 0, then segment-on masks for COM0, COM1, COM2, COM3
// Bitmap bit 0 is segment a, mask bit 4c+l is line l of character c
// Blank glass
0000 0000 0000 0000 0000 0000 0000 0000 00000000 00000000 00000000 00000000
// Every segment lit, FED line stays off on COM0
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF DDDDDDDD FFFFFFFF FFFFFFFF FFFFFFFF
// Segment a only
0001 0001 0001 0001 0001 0001 0001 0001 11111111 00000000 00000000 00000000
// One letter per character, p down to h
4000 2000 1000 0800 0400 0200 0100 0080 00000048 00000400 00084000 14800000
// One letter per character, g down to a, char 0 blank
0040 0020 0010 0008 0004 0002 0001 0000 00000010 82000100 00201000 00020000
// Mixed patterns
5555 2AAA 0F0F 70F0 1234 6DB6 0000 7FFF 58580C0D 875A630F 78D23F0F 962D850F

//--- sim.f
+incdir+.
lcdGlassPkg.sv
lcdDrivePkg.sv
lcdPhaseSequencer.sv
lcdBiasPwm.sv
lcdSegmentSelect.sv
lcdLevelDriver.sv
lcdTop.sv
lcd_properties.sv
lcdTb.sv
